/* vdp_cmd_pkg.sv */
// Shared definitions for the Graphic 4 command engine
// Coordinate and address widths, command and logical-operation codes,
// and the register numbers of R32..R46 as seen on the CPU port
package vdp_cmd_pkg;

  // Widths
  localparam int X_W    = 10;        // X coordinate and NX count
  localparam int Y_W    = 10;        // Y coordinate and NY count
  localparam int ADDR_W = 17;        // 128 KB of VRAM

  // Command codes, CMR[7:4]
  localparam logic [3:0] CMD_HMMV  = 4'b1100;  // byte fill
  localparam logic [3:0] CMD_LMMV  = 4'b1000;  // logical dot fill
  localparam logic [3:0] CMD_PSET  = 4'b0101;  // single dot
  localparam logic [3:0] CMD_POINT = 4'b0100;  // dot readback

  // Logical operations, CMR[2:0]
  localparam logic [2:0] LOP_IMP = 3'b000;     // DC = SC
  localparam logic [2:0] LOP_AND = 3'b001;     // DC = SC & DC
  localparam logic [2:0] LOP_OR  = 3'b010;     // DC = SC | DC
  localparam logic [2:0] LOP_XOR = 3'b011;     // DC = SC ^ DC
  localparam logic [2:0] LOP_NOT = 3'b100;     // DC = ~SC
  localparam int         LOP_T_BIT = 3;        // Transparent flag

  // Register numbers, offset from R32
  localparam logic [3:0] REG_SX_L = 4'd0;
  localparam logic [3:0] REG_SX_H = 4'd1;
  localparam logic [3:0] REG_SY_L = 4'd2;
  localparam logic [3:0] REG_SY_H = 4'd3;
  localparam logic [3:0] REG_DX_L = 4'd4;
  localparam logic [3:0] REG_DX_H = 4'd5;
  localparam logic [3:0] REG_DY_L = 4'd6;
  localparam logic [3:0] REG_DY_H = 4'd7;
  localparam logic [3:0] REG_NX_L = 4'd8;
  localparam logic [3:0] REG_NX_H = 4'd9;
  localparam logic [3:0] REG_NY_L = 4'd10;
  localparam logic [3:0] REG_NY_H = 4'd11;
  localparam logic [3:0] REG_CLR  = 4'd12;     // R44
  localparam logic [3:0] REG_ARG  = 4'd13;     // R45, DIX and DIY
  localparam logic [3:0] REG_CMR  = 4'd14;     // R46, starts a command

  localparam logic [7:0] PIX_MASK = 8'h0F;     // One 4-bit pixel

endpackage

/* vdp_cmd_regs.sv */
// Command register file, R32..R46
// CPU writes arrive on a toggle req/ack pair and are acknowledged
// on the next clock edge. An R46 write latches CMR and pulses cmd_start.
// The sequencer can overwrite CLR to return a POINT result.
`timescale 1ns/1ps

module vdp_cmd_regs (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        reg_wr_req,
  input  logic [3:0]                  reg_num,
  input  logic [7:0]                  reg_data,
  input  logic                        clr_load,
  input  logic [7:0]                  clr_load_data,
  output logic                        reg_wr_ack,
  output logic [vdp_cmd_pkg::X_W-1:0] sx,
  output logic [vdp_cmd_pkg::Y_W-1:0] sy,
  output logic [vdp_cmd_pkg::X_W-1:0] dx,
  output logic [vdp_cmd_pkg::Y_W-1:0] dy,
  output logic [vdp_cmd_pkg::X_W-1:0] nx,
  output logic [vdp_cmd_pkg::Y_W-1:0] ny,
  output logic [7:0]                  clr,
  output logic                        dix,
  output logic                        diy,
  output logic [7:0]                  cmr,
  output logic                        cmd_start
);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      reg_wr_ack <= 1'b0;
      sx         <= '0;
      sy         <= '0;
      dx         <= '0;
      dy         <= '0;
      nx         <= '0;
      ny         <= '0;
      clr        <= '0;
      dix        <= 1'b0;
      diy        <= 1'b0;
      cmr        <= '0;
      cmd_start  <= 1'b0;
    end else begin
      cmd_start <= 1'b0;                       // Single-cycle strobe
      if (clr_load)
        clr <= clr_load_data;                  // POINT result
      if (reg_wr_req != reg_wr_ack) begin      // Write pending
        reg_wr_ack <= ~reg_wr_ack;
        case (reg_num)
          vdp_cmd_pkg::REG_SX_L: sx[7:0] <= reg_data;
          vdp_cmd_pkg::REG_SX_H: sx[vdp_cmd_pkg::X_W-1:8] <= reg_data[1:0];
          vdp_cmd_pkg::REG_SY_L: sy[7:0] <= reg_data;
          vdp_cmd_pkg::REG_SY_H: sy[vdp_cmd_pkg::Y_W-1:8] <= reg_data[1:0];
          vdp_cmd_pkg::REG_DX_L: dx[7:0] <= reg_data;
          vdp_cmd_pkg::REG_DX_H: dx[vdp_cmd_pkg::X_W-1:8] <= reg_data[1:0];
          vdp_cmd_pkg::REG_DY_L: dy[7:0] <= reg_data;
          vdp_cmd_pkg::REG_DY_H: dy[vdp_cmd_pkg::Y_W-1:8] <= reg_data[1:0];
          vdp_cmd_pkg::REG_NX_L: nx[7:0] <= reg_data;
          vdp_cmd_pkg::REG_NX_H: nx[vdp_cmd_pkg::X_W-1:8] <= reg_data[1:0];
          vdp_cmd_pkg::REG_NY_L: ny[7:0] <= reg_data;
          vdp_cmd_pkg::REG_NY_H: ny[vdp_cmd_pkg::Y_W-1:8] <= reg_data[1:0];
          vdp_cmd_pkg::REG_CLR:  clr <= reg_data;   // Overrides clr_load
          vdp_cmd_pkg::REG_ARG: begin
            dix <= reg_data[2];
            diy <= reg_data[3];
          end
          vdp_cmd_pkg::REG_CMR: begin
            cmr       <= reg_data;
            cmd_start <= 1'b1;                 // Aborts anything running
          end
          default: ;                           // R47 and up ignored
        endcase
      end
    end
  end

endmodule

/* vdp_cmd_pixel.sv */
// Pixel datapath for Graphic 4
// Picks the addressed nibble out of a VRAM byte, applies the logical
// operation against the colour register and merges the result back.
`timescale 1ns/1ps

module vdp_cmd_pixel (
  input  logic [7:0] clr,
  input  logic [7:0] dst_byte,
  input  logic       x_odd,
  input  logic [3:0] lop,
  output logic [7:0] rd_pixel,
  output logic [7:0] wr_byte
);

  logic [7:0] src;       // Masked source colour
  logic [7:0] dst_pix;   // Destination pixel, right aligned
  logic [7:0] res;       // Pixel after the operation

  assign src = clr & vdp_cmd_pkg::PIX_MASK;

  // Even X sits in the high nibble
  assign dst_pix  = x_odd ? {4'h0, dst_byte[3:0]} : {4'h0, dst_byte[7:4]};
  assign rd_pixel = dst_pix;

  always_comb begin
    if (lop[vdp_cmd_pkg::LOP_T_BIT] && src == 8'h00) begin
      res = dst_pix;                           // Transparent colour 0
    end else begin
      case (lop[2:0])
        vdp_cmd_pkg::LOP_IMP: res = src;
        vdp_cmd_pkg::LOP_AND: res = src & dst_pix;
        vdp_cmd_pkg::LOP_OR:  res = src | dst_pix;
        vdp_cmd_pkg::LOP_XOR: res = src ^ dst_pix;
        vdp_cmd_pkg::LOP_NOT: res = ~src;      // Upper bits dropped below
        default:              res = dst_pix;   // 5..7 leave it alone
      endcase
    end
  end

  // Other nibble passes through
  always_comb begin
    if (x_odd)
      wr_byte = {dst_byte[7:4], res[3:0]};
    else
      wr_byte = {res[3:0], dst_byte[3:0]};
  end

endmodule

/* vdp_cmd_seq.sv */
// Command sequencer for HMMV, LMMV, PSET and POINT
// Walks the destination rectangle with working copies of DX, DY, NX, NY,
// drives the VRAM read and write toggle handshakes and forms the
// Graphic 4 byte address. Pauses while a CPU register write is pending.
`timescale 1ns/1ps

module vdp_cmd_seq (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           hold,
  input  logic                           cmd_start,
  input  logic [7:0]                     cmr,
  input  logic [vdp_cmd_pkg::X_W-1:0]    sx,
  input  logic [vdp_cmd_pkg::Y_W-1:0]    sy,
  input  logic [vdp_cmd_pkg::X_W-1:0]    dx,
  input  logic [vdp_cmd_pkg::Y_W-1:0]    dy,
  input  logic [vdp_cmd_pkg::X_W-1:0]    nx,
  input  logic [vdp_cmd_pkg::Y_W-1:0]    ny,
  input  logic                           dix,
  input  logic                           diy,
  input  logic [7:0]                     clr,
  input  logic                           vram_rd_ack,
  input  logic                           vram_wr_ack,
  input  logic [7:0]                     vram_rd_data,
  input  logic [7:0]                     rd_pixel,
  input  logic [7:0]                     wr_byte,
  output logic                           ce,
  output logic                           vram_rd_req,
  output logic                           vram_wr_req,
  output logic [vdp_cmd_pkg::ADDR_W-1:0] vram_addr,
  output logic [7:0]                     vram_wr_data,
  output logic [7:0]                     dst_byte,
  output logic                           x_odd,
  output logic                           clr_load,
  output logic [7:0]                     clr_load_data
);

  localparam logic [3:0] IDLE        = 4'd0;
  localparam logic [3:0] CHK_LOOP    = 4'd1;
  localparam logic [3:0] PRE_RD      = 4'd2;
  localparam logic [3:0] WAIT_PRE_RD = 4'd3;
  localparam logic [3:0] WR          = 4'd4;
  localparam logic [3:0] WAIT_WR     = 4'd5;
  localparam logic [3:0] RD          = 4'd6;
  localparam logic [3:0] WAIT_RD     = 4'd7;
  localparam logic [3:0] EXEC_END    = 4'd8;

  logic [3:0]                     state;
  logic                           init;      // First pass through CHK_LOOP
  logic [vdp_cmd_pkg::X_W-1:0]    dx_w;
  logic [vdp_cmd_pkg::X_W-1:0]    nx_w;      // Columns left in this row
  logic [vdp_cmd_pkg::Y_W-1:0]    dy_w;
  logic [vdp_cmd_pkg::Y_W-1:0]    ny_w;      // Rows left, this one included
  logic [3:0]                     cmd;
  logic                           is_hmmv;
  logic [vdp_cmd_pkg::X_W-1:0]    x_step;
  logic [vdp_cmd_pkg::X_W-1:0]    nx_init;
  logic [vdp_cmd_pkg::Y_W-1:0]    y_step;
  logic                           nx_end;
  logic                           ny_end;
  logic [vdp_cmd_pkg::ADDR_W-1:0] dst_addr;
  logic [vdp_cmd_pkg::ADDR_W-1:0] src_addr;

  assign cmd     = cmr[7:4];
  assign is_hmmv = (cmd == vdp_cmd_pkg::CMD_HMMV);

  // HMMV moves a byte (two pixels) at a time
  assign x_step  = is_hmmv ? (dix ? 10'h3FE : 10'h002) : (dix ? 10'h3FF : 10'h001);
  assign y_step  = diy ? 10'h3FF : 10'h001;
  assign nx_init = is_hmmv ? {1'b0, nx[vdp_cmd_pkg::X_W-1:1]} : nx;

  assign nx_end = (nx_w == '0) || dx_w[8];             // Count done or off screen
  assign ny_end = (ny_w == 10'd1) || (diy && dy_w == '0);

  assign dst_addr = {dy_w, dx_w[7:1]};
  assign src_addr = {sy, sx[7:1]};

  // POINT result goes straight into CLR as ce falls
  assign clr_load      = (state == EXEC_END) && (cmd == vdp_cmd_pkg::CMD_POINT) && !hold;
  assign clr_load_data = rd_pixel;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state        <= IDLE;
      init         <= 1'b0;
      ce           <= 1'b0;
      dx_w         <= '0;
      nx_w         <= '0;
      dy_w         <= '0;
      ny_w         <= '0;
      vram_rd_req  <= 1'b0;
      vram_wr_req  <= 1'b0;
      vram_addr    <= '0;
      vram_wr_data <= '0;
      dst_byte     <= '0;
      x_odd        <= 1'b0;
    end else if (cmd_start) begin            // New command, even mid-run
      ce    <= 1'b1;
      init  <= 1'b1;
      dx_w  <= dx;
      dy_w  <= dy;
      nx_w  <= nx_init;
      ny_w  <= ny;
      state <= CHK_LOOP;
    end else if (!hold) begin                // CPU write takes the cycle
      case (state)
        CHK_LOOP: begin
          init <= 1'b0;
          if (!init && nx_end && ny_end) begin
            state <= EXEC_END;
          end else begin
            case (cmd)
              vdp_cmd_pkg::CMD_HMMV:  state <= WR;
              vdp_cmd_pkg::CMD_LMMV:  state <= PRE_RD;
              vdp_cmd_pkg::CMD_PSET:  state <= PRE_RD;
              vdp_cmd_pkg::CMD_POINT: state <= RD;
              default:                state <= EXEC_END;  // Unsupported code
            endcase
          end
          if (!init && nx_end) begin         // Next row
            dx_w <= dx;
            nx_w <= nx_init;
            dy_w <= dy_w + y_step;
            ny_w <= ny_w - 10'd1;
          end
        end
        PRE_RD: begin
          if (vram_rd_req == vram_rd_ack) begin  // Let a stale access finish
            vram_addr   <= dst_addr;
            x_odd       <= dx_w[0];
            vram_rd_req <= ~vram_rd_ack;
            state       <= WAIT_PRE_RD;
          end
        end
        WAIT_PRE_RD: begin
          if (vram_rd_req == vram_rd_ack) begin
            dst_byte <= vram_rd_data;
            state    <= WR;
          end
        end
        WR: begin
          if (vram_wr_req == vram_wr_ack) begin
            vram_addr    <= dst_addr;
            vram_wr_data <= is_hmmv ? clr : wr_byte;  // Whole byte for HMMV
            vram_wr_req  <= ~vram_wr_ack;
            state        <= WAIT_WR;
          end
        end
        WAIT_WR: begin
          if (vram_wr_req == vram_wr_ack) begin
            if (cmd == vdp_cmd_pkg::CMD_PSET) begin
              state <= EXEC_END;
            end else begin
              dx_w  <= dx_w + x_step;
              nx_w  <= nx_w - 10'd1;
              state <= CHK_LOOP;
            end
          end
        end
        RD: begin
          if (vram_rd_req == vram_rd_ack) begin
            vram_addr   <= src_addr;         // POINT uses SX, SY
            x_odd       <= sx[0];
            vram_rd_req <= ~vram_rd_ack;
            state       <= WAIT_RD;
          end
        end
        WAIT_RD: begin
          if (vram_rd_req == vram_rd_ack) begin
            dst_byte <= vram_rd_data;
            state    <= EXEC_END;
          end
        end
        EXEC_END: begin
          ce    <= 1'b0;
          state <= IDLE;
        end
        default: state <= IDLE;              // IDLE waits for cmd_start
      endcase
    end
  end

endmodule

/* vdp_cmd_top.sv */
// Graphic 4 command engine top level
// Ties the CPU register port, the sequencer and the pixel datapath
// together. A pending CPU write holds the sequencer for that cycle.
`timescale 1ns/1ps

module vdp_cmd_top (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           reg_wr_req,
  output logic                           reg_wr_ack,
  input  logic [3:0]                     reg_num,
  input  logic [7:0]                     reg_data,
  output logic [vdp_cmd_pkg::ADDR_W-1:0] vram_addr,
  output logic [7:0]                     vram_wr_data,
  output logic                           vram_rd_req,
  output logic                           vram_wr_req,
  input  logic                           vram_rd_ack,
  input  logic                           vram_wr_ack,
  input  logic [7:0]                     vram_rd_data,
  output logic                           ce,
  output logic [7:0]                     clr
);

  logic [vdp_cmd_pkg::X_W-1:0] sx;
  logic [vdp_cmd_pkg::Y_W-1:0] sy;
  logic [vdp_cmd_pkg::X_W-1:0] dx;
  logic [vdp_cmd_pkg::Y_W-1:0] dy;
  logic [vdp_cmd_pkg::X_W-1:0] nx;
  logic [vdp_cmd_pkg::Y_W-1:0] ny;
  logic                        dix;
  logic                        diy;
  logic [7:0]                  cmr;
  logic                        cmd_start;
  logic                        clr_load;
  logic [7:0]                  clr_load_data;
  logic [7:0]                  dst_byte;
  logic                        x_odd;
  logic [7:0]                  rd_pixel;
  logic [7:0]                  wr_byte;
  logic                        hold;

  assign hold = (reg_wr_req != reg_wr_ack);  // CPU write pending

  vdp_cmd_regs regs0 (
    .clk, .reset, .reg_wr_req, .reg_num, .reg_data, .clr_load, .clr_load_data,
    .reg_wr_ack, .sx, .sy, .dx, .dy, .nx, .ny, .clr, .dix, .diy, .cmr, .cmd_start
  );

  vdp_cmd_seq seq0 (
    .clk, .reset, .hold, .cmd_start, .cmr, .sx, .sy, .dx, .dy, .nx, .ny,
    .dix, .diy, .clr, .vram_rd_ack, .vram_wr_ack, .vram_rd_data, .rd_pixel,
    .wr_byte, .ce, .vram_rd_req, .vram_wr_req, .vram_addr, .vram_wr_data,
    .dst_byte, .x_odd, .clr_load, .clr_load_data
  );

  vdp_cmd_pixel pix0 (
    .clr      (clr),
    .dst_byte (dst_byte),
    .x_odd    (x_odd),
    .lop      (cmr[3:0]),                   // Transparent flag and operation
    .rd_pixel (rd_pixel),
    .wr_byte  (wr_byte)
  );

endmodule

/* tb_vdp_cmd.sv */
// Testbench for the Graphic 4 command engine
// Drives the CPU register port, serves VRAM through a byte array with
// random ack latency and checks PSET, LMMV, HMMV and POINT against a
// reference model that keeps its own copy of VRAM
`timescale 1ns/1ps

module tb_vdp_cmd;

  logic                           clk = 1'b0;
  logic                           reset;
  logic                           reg_wr_req;
  logic                           reg_wr_ack;
  logic [3:0]                     reg_num;
  logic [7:0]                     reg_data;
  logic [vdp_cmd_pkg::ADDR_W-1:0] vram_addr;
  logic [7:0]                     vram_wr_data;
  logic                           vram_rd_req;
  logic                           vram_wr_req;
  logic                           vram_rd_ack;
  logic                           vram_wr_ack;
  logic [7:0]                     vram_rd_data;
  logic                           ce;
  logic [7:0]                     clr;

  logic [7:0]  mem     [0:131071];   // VRAM as the DUT sees it
  logic [7:0]  ref_mem [0:131071];   // Model copy
  logic [31:0] lfsr    = 32'h56960adb;
  logic [2:0]  lat_cfg = 3'd1;       // Ack latency of 1..4 cycles

  always #50 clk = ~clk;             // 100 ns period

  vdp_cmd_top dut0 (
    .clk, .reset, .reg_wr_req, .reg_wr_ack, .reg_num, .reg_data,
    .vram_addr, .vram_wr_data, .vram_rd_req, .vram_wr_req,
    .vram_rd_ack, .vram_wr_ack, .vram_rd_data, .ce, .clr
  );

  // Fibonacci LFSR with taps 32 22 2 1 and one step per bit
  function automatic logic [31:0] rnd(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
    if (exp_v !== act_v) begin
      $display("CHECK FAILED at %0t: %s expected %0h actual %0h", $time, name, exp_v, act_v);
      $display("Verification failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR at %0t: %s", $time, what);
    $display("Verification failed");
    $fatal(1, "stopped on timeout");
  endtask

  // VRAM model serving both toggle handshakes after lat_cfg edges
  initial begin
    logic [2:0] rd_cnt;
    logic [2:0] wr_cnt;
    rd_cnt = 3'd0;
    wr_cnt = 3'd0;
    vram_rd_ack  <= 1'b0;
    vram_wr_ack  <= 1'b0;
    vram_rd_data <= 8'h00;
    @(posedge clk);                        // Model preload is done by now
    for (int i = 0; i < 131072; i++)
      mem[17'(i)] = ref_mem[17'(i)];
    forever begin
      if (vram_rd_req != vram_rd_ack) begin
        if (rd_cnt == lat_cfg - 3'd1) begin
          vram_rd_data <= mem[vram_addr];
          vram_rd_ack  <= vram_rd_req;
          rd_cnt = 3'd0;
        end else
          rd_cnt = rd_cnt + 3'd1;
      end
      if (vram_wr_req != vram_wr_ack) begin
        if (wr_cnt == lat_cfg - 3'd1) begin
          mem[vram_addr] = vram_wr_data;
          vram_wr_ack <= vram_wr_req;
          wr_cnt = 3'd0;
        end else
          wr_cnt = wr_cnt + 3'd1;
      end
      @(posedge clk);
    end
  end

  // One register write whose ack follows exactly one edge later
  task automatic write_reg(input logic [3:0] num, input logic [7:0] data);
    logic ack_before;
    ack_before = reg_wr_ack;
    @(posedge clk);
    reg_num    <= num;
    reg_data   <= data;
    reg_wr_req <= ~reg_wr_req;
    @(negedge clk);
    check("reg_wr_ack", 32'(ack_before), 32'(reg_wr_ack));   // Not yet
    @(negedge clk);
    check("reg_wr_ack", 32'(reg_wr_req), 32'(reg_wr_ack));
  endtask

  task automatic write_pair(input logic [3:0] lo_num, input logic [9:0] val);
    write_reg(lo_num, val[7:0]);
    write_reg(lo_num + 4'd1, {6'h00, val[9:8]});             // Upper 2 bits
  endtask

  task automatic setup_regs(input logic [9:0] x, input logic [9:0] y, input logic [9:0] w,
                            input logic [9:0] h, input logic [7:0] colour,
                            input logic dix, input logic diy);
    write_pair(vdp_cmd_pkg::REG_DX_L, x);
    write_pair(vdp_cmd_pkg::REG_DY_L, y);
    write_pair(vdp_cmd_pkg::REG_NX_L, w);
    write_pair(vdp_cmd_pkg::REG_NY_L, h);
    write_reg(vdp_cmd_pkg::REG_CLR, colour);
    write_reg(vdp_cmd_pkg::REG_ARG, {4'h0, diy, dix, 2'b00});
  endtask

  // Start through R46 and wait for ce to rise and fall
  task automatic run_cmd(input logic [7:0] cmr_v);
    int n;
    write_reg(vdp_cmd_pkg::REG_CMR, cmr_v);
    n = 0;
    while (!ce) begin
      if (n == 2)
        report_timeout("ce did not rise within 2 cycles of the R46 write");
      @(negedge clk);
      n++;
    end
    n = 0;
    while (ce) begin
      if (n == 4000)
        report_timeout("command did not finish, ce stayed high");
      @(negedge clk);
      n++;
    end
    check("vram_rd_req", 32'(vram_rd_ack), 32'(vram_rd_req));   // Nothing left open
    check("vram_wr_req", 32'(vram_wr_ack), 32'(vram_wr_req));
  endtask

  // Logical operation on one nibble where T skips colour 0
  function automatic logic [3:0] lop_model(input logic [3:0] src, input logic [3:0] dst,
                                           input logic [3:0] lop);
    if (lop[vdp_cmd_pkg::LOP_T_BIT] && src == 4'h0)
      return dst;
    case (lop[2:0])
      vdp_cmd_pkg::LOP_IMP: return src;
      vdp_cmd_pkg::LOP_AND: return src & dst;
      vdp_cmd_pkg::LOP_OR:  return src | dst;
      vdp_cmd_pkg::LOP_XOR: return src ^ dst;
      vdp_cmd_pkg::LOP_NOT: return ~src;
      default:              return dst;
    endcase
  endfunction

  task automatic model_pixel(input logic [9:0] x, input logic [9:0] y,
                             input logic [7:0] colour, input logic [3:0] lop);
    logic [16:0] a;
    logic [7:0]  b;
    a = {y, x[7:1]};                       // Two pixels per byte
    b = ref_mem[a];
    if (x[0])
      b[3:0] = lop_model(colour[3:0], b[3:0], lop);
    else
      b[7:4] = lop_model(colour[3:0], b[7:4], lop);   // Even X high nibble
    ref_mem[a] = b;
  endtask

  // Rectangle walk for LMMV (dots) and HMMV (bytes)
  task automatic model_rect(input logic [9:0] x0, input logic [9:0] y0, input logic [9:0] w,
                            input logic [9:0] h, input logic [7:0] colour, input logic dix,
                            input logic diy, input logic [3:0] lop, input logic hmmv);
    logic [9:0] x;
    logic [9:0] y;
    logic [9:0] n;
    logic [9:0] rows;
    logic [9:0] step;
    logic       done;
    step = hmmv ? 10'd2 : 10'd1;           // HMMV moves a whole byte
    y    = y0;
    rows = h;
    done = 1'b0;
    while (!done) begin
      x = x0;
      n = hmmv ? w / 10'd2 : w;            // NX/2 bytes per row
      do begin
        if (hmmv)
          ref_mem[{y, x[7:1]}] = colour;
        else
          model_pixel(x, y, colour, lop);
        x = dix ? x - step : x + step;
        n = n - 10'd1;
      end while (n != 10'd0 && !x[8]);     // Count out or off the line
      if (rows == 10'd1 || (diy && y == 10'd0))
        done = 1'b1;
      else begin
        y    = diy ? y - 10'd1 : y + 10'd1;
        rows = rows - 10'd1;
      end
    end
  endtask

  task automatic compare_vram();
    for (int a = 0; a < 131072; a++)
      if (mem[17'(a)] !== ref_mem[17'(a)])
        check($sformatf("vram[%05h]", a), 32'(ref_mem[17'(a)]), 32'(mem[17'(a)]));
  endtask

  initial begin
    logic [9:0] x;
    logic [9:0] y;
    logic [9:0] w;
    logic [9:0] h;
    logic [7:0] colour;
    logic [7:0] b;
    logic [3:0] nib;
    logic [3:0] lop;
    logic [2:0] op;
    logic       t;
    logic       dix;
    logic       diy;
    reset      <= 1'b1;
    reg_wr_req <= 1'b0;
    reg_num    <= 4'h0;
    reg_data   <= 8'h00;
    for (int i = 0; i < 131072; i++)
      ref_mem[17'(i)] = 8'(rnd(8));        // Random VRAM contents
    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check("ce", 32'd0, 32'(ce));
    check("vram_rd_req", 32'(vram_rd_ack), 32'(vram_rd_req));
    check("vram_wr_req", 32'(vram_wr_ack), 32'(vram_wr_req));

    // PSET through every operation with and without T
    for (int k = 0; k < 10; k++) begin
      op     = 3'(k % 5);
      t      = (k >= 5);
      x      = 10'(rnd(8));
      y      = 10'(rnd(10));
      colour = 8'(rnd(8));
      if (t && rnd(1) != 0)
        colour[3:0] = 4'h0;                // Hit the transparent case
      lat_cfg = 3'(rnd(2) + 1);
      lop     = {t, op};
      setup_regs(x, y, 10'd1, 10'd1, colour, 1'b0, 1'b0);
      run_cmd({vdp_cmd_pkg::CMD_PSET, lop});
      model_pixel(x, y, colour, lop);
      compare_vram();
    end

    // LMMV over random rectangles favouring the X edges and Y 0
    for (int k = 0; k < 16; k++) begin
      dix = 1'(rnd(1));
      diy = 1'(rnd(1));
      if (rnd(1) != 0)
        x = dix ? 10'(rnd(2)) : 10'(252 + rnd(2));
      else
        x = 10'(rnd(8));
      y      = (rnd(1) != 0) ? 10'(rnd(2)) : 10'(rnd(10));
      w      = 10'(rnd(3) + 1);
      h      = 10'(rnd(3) + 1);
      colour = 8'(rnd(8));
      op     = 3'(rnd(3));
      if (op > 3'd4)
        op = op - 3'd4;
      t       = 1'(rnd(1));
      lop     = {t, op};
      lat_cfg = 3'(rnd(2) + 1);
      setup_regs(x, y, w, h, colour, dix, diy);
      run_cmd({vdp_cmd_pkg::CMD_LMMV, lop});
      model_rect(x, y, w, h, colour, dix, diy, lop, 1'b0);
      compare_vram();
    end

    // HMMV with even widths only
    for (int k = 0; k < 8; k++) begin
      dix     = 1'(rnd(1));
      diy     = 1'(rnd(1));
      x       = 10'(rnd(8));
      y       = (rnd(1) != 0) ? 10'(rnd(2)) : 10'(rnd(10));
      w       = 10'((rnd(2) + 1) * 2);
      h       = 10'(rnd(3) + 1);
      colour  = 8'(rnd(8));
      lat_cfg = 3'(rnd(2) + 1);
      setup_regs(x, y, w, h, colour, dix, diy);
      run_cmd({vdp_cmd_pkg::CMD_HMMV, 4'h0});
      model_rect(x, y, w, h, colour, dix, diy, 4'h0, 1'b1);
      compare_vram();
    end

    // POINT reads back into CLR
    for (int k = 0; k < 8; k++) begin
      x       = 10'(rnd(8));
      y       = 10'(rnd(10));
      lat_cfg = 3'(rnd(2) + 1);
      write_pair(vdp_cmd_pkg::REG_SX_L, x);
      write_pair(vdp_cmd_pkg::REG_SY_L, y);
      run_cmd({vdp_cmd_pkg::CMD_POINT, 4'h0});
      b   = ref_mem[{y, x[7:1]}];
      nib = x[0] ? b[3:0] : b[7:4];
      check("clr", 32'({4'h0, nib}), 32'(clr));
      compare_vram();                      // Read only
    end

    $display("Verification passed");
    $finish;
  end

endmodule

/* list.f */
vdp_cmd_pkg.sv
vdp_cmd_regs.sv
vdp_cmd_pixel.sv
vdp_cmd_seq.sv
vdp_cmd_top.sv
tb_vdp_cmd.sv

/* run.sh */
#!/bin/sh
# Build and run the command engine testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timescale 1ns/1ps -f list.f --top-module tb_vdp_cmd \
  -Mdir obj_dir -o sim_vdp_cmd
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_vdp_cmd > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q "Verification failed" sim.log; then
  echo "FAIL"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi
echo "PASS"
exit 0
